// ==== all.f ====
hdl/life_pkg.sv
hdl/board_if.sv
hdl/life_board.sv
hdl/life_stepper.sv
hdl/board_printer.sv
hdl/life_ctrl.sv
hdl/life_top.sv
dv/life_props.sv
dv/tb_life.sv

// ==== dv/life_props.sv ====
// ******************************
// Stream protocol checks bound into life_top
// Sampled on the rising clock edge
// ******************************

module life_props (
  input logic            clk,
  input logic            boot_reset,
  input logic            cmd_ready,
  input logic            out_valid,
  input logic            out_ready,
  input life_pkg::byte_t out_data
);

  timeunit 1ns;
  timeprecision 100ps;

  // A stalled output byte is held as it is
  a_out_hold: assert property (@(posedge clk) disable iff (boot_reset)
    out_valid && !out_ready |=> $stable(out_valid) && $stable(out_data))
    else $error("output byte changed while out_ready was low");

  a_one_side: assert property (@(posedge clk) disable iff (boot_reset)
    !(cmd_ready && out_valid))
    else $error("cmd_ready and out_valid high together");

  a_after_reset: assert property (@(posedge clk)
    boot_reset |=> !cmd_ready && !out_valid)
    else $error("stream handshakes active right after reset");

endmodule

bind life_top life_props u_props (
  .clk        (clk),
  .boot_reset (boot_reset),
  .cmd_ready  (cmd_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_data   (out_data)
);

// ==== dv/tb_life.sv ====
// ******************************
// Testbench for life_top
// out_ready is random, about 3 cycles in 4 high
// Expected boards come from a torus model and an LFSR model
// Frames are taken as 84 bytes each, no resync after a lost byte
// ******************************

module tb_life;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FRAME_LEN = 4 + life_pkg::HEIGHT * (life_pkg::WIDTH + 2);
  localparam int PRINT_CYCLES = 4 * FRAME_LEN;
  localparam int FRAME_CYCLES = 576 + 64 + PRINT_CYCLES;  // Update, copy, print
  localparam int WATCHDOG_CYCLES = 20 * FRAME_CYCLES;
  localparam int RUN_PERIOD = int'(life_pkg::RUN_INTERVAL) + FRAME_CYCLES;

  logic            clk;
  logic            boot_reset;
  life_pkg::byte_t cmd_data;
  logic            cmd_valid;
  logic            cmd_ready;
  life_pkg::byte_t out_data;
  logic            out_valid;
  logic            out_ready;

  integer seed = 80;
  logic [15:0] model_lfsr = life_pkg::LFSR_SEED;
  logic [life_pkg::CELLS-1:0] cur_board;
  logic [life_pkg::CELLS-1:0] exp_boards[$];
  string exp_names[$];
  life_pkg::byte_t frame_buf[$];  // Bytes of the frame being collected
  int frames_seen = 0;
  int tests_run = 0;
  int tests_failed = 0;
  event frame_ready;

  life_top u_life_top (
    .clk        (clk),
    .boot_reset (boot_reset),
    .cmd_data   (cmd_data),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  function automatic life_pkg::cell_idx_t cell_at(input int r, input int c);
    return life_pkg::cell_idx_t'(r * life_pkg::WIDTH + c);
  endfunction

  // Torus rule, birth on 3, survival on 2 or 3
  function automatic logic [life_pkg::CELLS-1:0] next_gen(input logic [life_pkg::CELLS-1:0] b);
    logic [life_pkg::CELLS-1:0] n;
    int cnt;
    for (int r = 0; r < life_pkg::HEIGHT; r++) begin
      for (int c = 0; c < life_pkg::WIDTH; c++) begin
        cnt = 0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            if (dr != 0 || dc != 0) begin
              cnt = cnt + int'(b[cell_at((r + dr + 8) % 8, (c + dc + 8) % 8)]);
            end
          end
        end
        n[cell_at(r, c)] = (cnt == 3) || (cnt == 2 && b[cell_at(r, c)]);
      end
    end
    return n;
  endfunction

  // Byte k of the frame for board b
  function automatic life_pkg::byte_t frame_byte(input logic [life_pkg::CELLS-1:0] b, input int k);
    int row;
    int pos;
    if (k == 0) return 8'h1B;  // ESC
    if (k == 1) return "[";
    if (k == 2) return ";";
    if (k == 3) return "H";
    row = (k - 4) / 10;
    pos = (k - 4) % 10;
    if (pos == 8) return 8'h0D;
    if (pos == 9) return 8'h0A;
    return b[cell_at(row, pos)] ? "O" : " ";
  endfunction

  task automatic random_board();
    logic fb;
    for (int i = 0; i < life_pkg::CELLS; i++) begin
      fb = model_lfsr[15] ^ model_lfsr[13] ^ model_lfsr[12] ^ model_lfsr[10];
      model_lfsr = {model_lfsr[14:0], fb};
      cur_board[life_pkg::cell_idx_t'(i)] = model_lfsr[0];
    end
  endtask

  task automatic record_result(input string name, input bit ok);
    tests_run++;
    if (!ok) tests_failed++;
    $display("%s: %s", name, ok ? "pass" : "FAIL");
  endtask

  task automatic check_frame();
    logic [life_pkg::CELLS-1:0] board;
    string name;
    int bad;
    bad = -1;
    frames_seen++;
    if (exp_boards.size() == 0) begin
      $display("A frame arrived that no command asked for");
      record_result("unexpected_frame", 1'b0);
    end else begin
      board = exp_boards.pop_front();
      name = exp_names.pop_front();
      for (int k = 0; k < FRAME_LEN; k++) begin
        if (bad < 0 && frame_buf[k] != frame_byte(board, k)) bad = k;
      end
      if (bad >= 0) begin
        $display("Error %s: byte %0d expected %02h, actual %02h", name, bad,
                 frame_byte(board, bad), frame_buf[bad]);
      end
      record_result(name, bad < 0);
    end
    frame_buf.delete();
  endtask

  // Holds the byte until cmd_ready is seen, transfer on the next edge
  task automatic send_cmd(input life_pkg::byte_t value);
    @(posedge clk);
    #1;
    cmd_data = value;
    cmd_valid = 1'b1;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_frames(input int target);
    while (frames_seen < target) @(posedge clk);
  endtask

  task automatic expect_frame(input life_pkg::byte_t value, input bit fresh, input string name);
    int target;
    target = frames_seen + 1;
    if (fresh) random_board();
    else cur_board = next_gen(cur_board);
    exp_boards.push_back(cur_board);
    exp_names.push_back(name);
    send_cmd(value);
    wait_frames(target);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      out_ready = (($random(seed) & 3) != 0);
    end
  end

  // Collector, a byte seen here transfers on the next rising edge
  always @(negedge clk) begin
    if (!boot_reset && out_valid && out_ready) begin
      frame_buf.push_back(out_data);
      if (frame_buf.size() == FRAME_LEN) -> frame_ready;
    end
  end

  initial begin
    forever begin
      @(frame_ready);
      check_frame();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int start_count;
    int waited;
    boot_reset = 1'b1;
    cmd_data = 8'h00;
    cmd_valid = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    boot_reset = 1'b0;

    expect_frame("x", 1'b1, "first_byte");
    expect_frame("1", 1'b0, "step");
    expect_frame("0", 1'b1, "random_again");
    expect_frame("1", 1'b0, "step_after_random_1");
    expect_frame("1", 1'b0, "step_after_random_2");

    start_count = frames_seen;
    send_cmd("q");
    waited = 0;
    @(negedge clk);
    while (!cmd_ready && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_ready) begin
      $display("cmd_ready did not come back after an ignored byte");
      record_result("ignored_byte", 1'b0);
    end else if (frames_seen != start_count || frame_buf.size() != 0 || out_valid) begin
      $display("Output started after an ignored byte");
      record_result("ignored_byte", 1'b0);
    end else begin
      record_result("ignored_byte", 1'b1);
    end
    expect_frame("1", 1'b0, "step_after_ignore");

    // Run mode, three generations without commands
    start_count = frames_seen;
    for (int g = 1; g <= 3; g++) begin
      cur_board = next_gen(cur_board);
      exp_boards.push_back(cur_board);
      exp_names.push_back($sformatf("run_gen_%0d", g));
    end
    send_cmd(" ");
    wait_frames(start_count + 3);
    send_cmd("1");
    start_count = frames_seen;
    repeat (3 * RUN_PERIOD) @(posedge clk);
    if (frames_seen != start_count || frame_buf.size() != 0) begin
      $display("Output continued after the run was stopped");
      record_result("run_stop", 1'b0);
    end else begin
      record_result("run_stop", 1'b1);
    end

    if (exp_boards.size() != 0) begin
      $display("%0d expected frames never arrived", exp_boards.size());
      record_result("missing_frames", 1'b0);
    end
    $display("%0d tests, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/board_if.sv ====
// ****************************
// Board access between the engines and the store
// Reads are combinational, the cell comes back in the
// same cycle as its address
// ****************************

interface board_if;

  life_pkg::cell_idx_t step_addr;   // Stepper read port
  logic                step_cell;
  life_pkg::cell_idx_t print_addr;  // Printer read port
  logic                print_cell;

  // Next-state write from the stepper
  logic                next_we;
  life_pkg::cell_idx_t next_addr;
  logic                next_cell;

  modport store (
    input  step_addr, print_addr, next_we, next_addr, next_cell,
    output step_cell, print_cell
  );

  modport stepper (
    output step_addr, next_we, next_addr, next_cell,
    input  step_cell
  );

  modport printer (
    output print_addr,
    input  print_cell
  );

endinterface

// ==== hdl/board_printer.sv ====
// ****************************
// Prints the board as home sequence, 8 rows of cells, CR LF
// Each byte is held with out_valid until it transfers, and the
// next one is loaded one cycle later, so a byte takes 2 cycles
// at least
// ****************************

module board_printer (
  input  logic             clk,
  input  logic             boot_reset,
  input  logic             print_start,
  input  logic             out_ready,
  output logic             print_done,
  output life_pkg::byte_t  out_data,
  output logic             out_valid,
  board_if.printer bus
);

  typedef enum logic [1:0] {
    ph_idle,
    ph_home,
    ph_cell,
    ph_crlf
  } phase_t;

  phase_t                     phase;
  life_pkg::cell_idx_t        cell_idx;
  logic [life_pkg::LOG_W-1:0] col;
  logic [1:0]                 seq_idx;  // Home byte, or 0 for CR and 1 for LF
  logic                       load;

  assign load = (phase != ph_idle) && !out_valid;
  assign bus.print_addr = cell_idx;

  always_ff @(posedge clk) begin
    if (load) begin
      case (phase)
        ph_home: out_data <= life_pkg::HOME_SEQ[seq_idx];
        ph_cell: out_data <= bus.print_cell ? life_pkg::CHAR_ALIVE : life_pkg::CHAR_DEAD;
        default: out_data <= seq_idx[0] ? life_pkg::CHAR_LF : life_pkg::CHAR_CR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      phase <= ph_idle;
      cell_idx <= '0;
      col <= '0;
      seq_idx <= '0;
      out_valid <= 1'b0;
      print_done <= 1'b0;
    end else begin
      print_done <= 1'b0;
      if (phase == ph_idle) begin
        if (print_start) begin
          phase <= ph_home;
          cell_idx <= '0;
          col <= '0;
          seq_idx <= '0;
        end
      end else if (load) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin  // Byte transfers on this edge
        out_valid <= 1'b0;
        case (phase)
          ph_home: begin
            seq_idx <= seq_idx + 2'd1;
            if (seq_idx == '1) phase <= ph_cell;  // Wraps to 0 for the cells
          end
          ph_cell: begin
            cell_idx <= cell_idx + 1'b1;
            col <= col + 1'b1;
            if (col == '1) begin  // End of row
              phase <= ph_crlf;
              seq_idx <= '0;
            end
          end
          default: begin
            if (seq_idx[0]) begin
              seq_idx <= '0;
              // cell_idx wrapped back to 0 after the last row
              if (cell_idx == '0) begin
                phase <= ph_idle;
                print_done <= 1'b1;
              end else begin
                phase <= ph_cell;
              end
            end else begin
              seq_idx <= 2'd1;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== hdl/life_board.sv ====
// ****************************
// Current and next board store
// Randomize and copy share one cell counter and take 64
// cycles each, done pulses the cycle after the last write
// Only one of rand_start and copy_start may be raised at a time
// ****************************

module life_board (
  input  logic clk,
  input  logic boot_reset,
  input  logic rand_start,
  input  logic copy_start,
  output logic rand_done,
  output logic copy_done,
  board_if.store bus
);

  logic [life_pkg::CELLS-1:0] cur;   // Current generation
  logic [life_pkg::CELLS-1:0] nxt;   // Next generation from the stepper
  logic [15:0]                lfsr;
  logic [15:0]                lfsr_next;
  logic                       lfsr_fb;
  life_pkg::cell_idx_t        cnt;
  logic                       rand_busy;
  logic                       copy_busy;

  // Fibonacci taps 16, 14, 13, 11
  assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
  assign lfsr_next = {lfsr[14:0], lfsr_fb};

  assign bus.step_cell = cur[bus.step_addr];
  assign bus.print_cell = cur[bus.print_addr];

  always_ff @(posedge clk) begin
    if (rand_busy) begin
      cur[cnt] <= lfsr_next[0];  // New bit 0 of the LFSR
    end else if (copy_busy) begin
      cur[cnt] <= nxt[cnt];
    end
    if (bus.next_we) begin
      nxt[bus.next_addr] <= bus.next_cell;
    end
  end

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      lfsr <= life_pkg::LFSR_SEED;
      cnt <= '0;
      rand_busy <= 1'b0;
      copy_busy <= 1'b0;
      rand_done <= 1'b0;
      copy_done <= 1'b0;
    end else begin
      rand_done <= 1'b0;
      copy_done <= 1'b0;
      if (rand_start) begin
        rand_busy <= 1'b1;
        cnt <= '0;
      end else if (copy_start) begin
        copy_busy <= 1'b1;
        cnt <= '0;
      end else if (rand_busy || copy_busy) begin
        if (rand_busy) lfsr <= lfsr_next;  // One step per written cell
        cnt <= cnt + 1'b1;
        // Last cell, all ones for a power of two board
        if (cnt == '1) begin
          rand_done <= rand_busy;
          copy_done <= copy_busy;
          rand_busy <= 1'b0;
          copy_busy <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hdl/life_ctrl.sv ====
// ****************************
// Command decoder and action sequencer
// cmd_ready is only high in init or idle, and drops the cycle
// before the run timer fires
// ****************************

module life_ctrl (
  input  logic            clk,
  input  logic            boot_reset,
  input  life_pkg::byte_t cmd_data,
  input  logic            cmd_valid,
  input  logic            rand_done,
  input  logic            update_done,
  input  logic            copy_done,
  input  logic            print_done,
  output logic            cmd_ready,
  output logic            rand_start,
  output logic            update_start,
  output logic            copy_start,
  output logic            print_start
);

  life_pkg::action_t action;
  logic              running;
  logic [15:0]       timer;
  logic              cmd_xfer;

  assign cmd_xfer = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      action <= life_pkg::act_init;
      running <= 1'b0;
      timer <= '0;
      cmd_ready <= 1'b0;
      rand_start <= 1'b0;
      update_start <= 1'b0;
      copy_start <= 1'b0;
      print_start <= 1'b0;
    end else begin
      cmd_ready <= 1'b0;
      rand_start <= 1'b0;
      update_start <= 1'b0;
      copy_start <= 1'b0;
      print_start <= 1'b0;
      case (action)
        life_pkg::act_init: begin
          if (cmd_xfer) begin  // Any first byte randomizes
            action <= life_pkg::act_random;
            rand_start <= 1'b1;
          end else begin
            cmd_ready <= 1'b1;
          end
        end
        life_pkg::act_idle: begin
          if (cmd_xfer) begin
            case (cmd_data)
              life_pkg::CMD_RANDOM: begin
                action <= life_pkg::act_random;
                rand_start <= 1'b1;
              end
              life_pkg::CMD_STEP: begin
                if (!running) begin
                  action <= life_pkg::act_update;
                  update_start <= 1'b1;
                end else begin
                  running <= 1'b0;  // Step while running stops the run
                  timer <= '0;
                end
              end
              life_pkg::CMD_RUN: begin
                running <= !running;
                timer <= '0;
              end
              default: ;  // Other bytes are dropped
            endcase
          end else if (running && timer == life_pkg::RUN_INTERVAL) begin
            timer <= '0;
            action <= life_pkg::act_update;
            update_start <= 1'b1;
          end else begin
            if (running) timer <= timer + 16'd1;
            cmd_ready <= !(running && timer == life_pkg::RUN_INTERVAL - 16'd1);
          end
        end
        life_pkg::act_random: begin
          if (rand_done) begin
            action <= life_pkg::act_print;
            print_start <= 1'b1;
          end
        end
        life_pkg::act_update: begin
          if (update_done) begin
            action <= life_pkg::act_copy;
            copy_start <= 1'b1;
          end
        end
        life_pkg::act_copy: begin
          if (copy_done) begin
            action <= life_pkg::act_print;
            print_start <= 1'b1;
          end
        end
        life_pkg::act_print: begin
          if (print_done) action <= life_pkg::act_idle;
        end
        default: action <= life_pkg::act_idle;
      endcase
    end
  end

endmodule

// ==== hdl/life_pkg.sv ====
// ****************************
// Shared constants and types of the Game of Life engine
// Board geometry is fixed at 8 by 8, and cell indices assume
// power of two sides (wrap by truncation)
// Characters and commands are plain ASCII bytes
// ****************************

package life_pkg;

  localparam int LOG_W = 3;
  localparam int LOG_H = 3;
  localparam int WIDTH = 1 << LOG_W;
  localparam int HEIGHT = 1 << LOG_H;
  localparam int CELLS = WIDTH * HEIGHT;

  // Row in the upper bits, column in the lower bits
  typedef logic [LOG_W+LOG_H-1:0] cell_idx_t;
  typedef logic [7:0] byte_t;

  localparam byte_t CHAR_ALIVE = 8'h4F;  // "O"
  localparam byte_t CHAR_DEAD = 8'h20;   // Space
  localparam byte_t CHAR_CR = 8'h0D;
  localparam byte_t CHAR_LF = 8'h0A;

  // Cursor home, ESC [ ; H, element 0 goes out first
  localparam int HOME_SEQ_LEN = 4;
  localparam logic [HOME_SEQ_LEN-1:0][7:0] HOME_SEQ = {8'h48, 8'h3B, 8'h5B, 8'h1B};

  localparam byte_t CMD_RANDOM = 8'h30;  // "0"
  localparam byte_t CMD_STEP = 8'h31;    // "1"
  localparam byte_t CMD_RUN = 8'h20;     // Space toggles run mode

  localparam logic [15:0] RUN_INTERVAL = 16'd64;  // Idle cycles between auto steps
  localparam logic [15:0] LFSR_SEED = 16'hACE1;

  typedef enum logic [2:0] {
    act_init,
    act_idle,
    act_random,
    act_update,
    act_copy,
    act_print
  } action_t;

endpackage

// ==== hdl/life_stepper.sv ====
// ****************************
// Next generation, one cell every 9 cycles
// Eight neighbour reads, then a write that reads the cell itself
// Neighbours wrap on both axes, 8 by 8 only
// ****************************

module life_stepper (
  input  logic clk,
  input  logic boot_reset,
  input  logic update_start,
  output logic update_done,
  board_if.stepper bus
);

  life_pkg::cell_idx_t          cell_idx;
  logic [3:0]                   neigh;  // 0 to 7 neighbours, 8 writes
  logic [3:0]                   count;
  logic                         busy;
  logic [life_pkg::LOG_H-1:0]   row;
  logic [life_pkg::LOG_W-1:0]   col;
  logic [life_pkg::LOG_H-1:0]   dy;
  logic [life_pkg::LOG_W-1:0]   dx;
  logic                         write_phase;

  assign row = cell_idx[life_pkg::LOG_W+life_pkg::LOG_H-1:life_pkg::LOG_W];
  assign col = cell_idx[life_pkg::LOG_W-1:0];
  assign write_phase = busy && (neigh == 4'd8);

  // Offsets, 3'd7 stands for -1 modulo 8
  always_comb begin
    case (neigh)
      4'd0: begin dy = 3'd7; dx = 3'd7; end
      4'd1: begin dy = 3'd7; dx = 3'd0; end
      4'd2: begin dy = 3'd7; dx = 3'd1; end
      4'd3: begin dy = 3'd0; dx = 3'd7; end
      4'd4: begin dy = 3'd0; dx = 3'd1; end
      4'd5: begin dy = 3'd1; dx = 3'd7; end
      4'd6: begin dy = 3'd1; dx = 3'd0; end
      4'd7: begin dy = 3'd1; dx = 3'd1; end
      default: begin dy = 3'd0; dx = 3'd0; end  // The cell itself
    endcase
  end

  assign bus.step_addr = {row + dy, col + dx};
  assign bus.next_we = write_phase;
  assign bus.next_addr = cell_idx;
  // Birth on 3, survival on 2 or 3
  assign bus.next_cell = (count == 4'd3) || (count == 4'd2 && bus.step_cell);

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      busy <= 1'b0;
      cell_idx <= '0;
      neigh <= '0;
      count <= '0;
      update_done <= 1'b0;
    end else begin
      update_done <= 1'b0;
      if (update_start) begin
        busy <= 1'b1;
        cell_idx <= '0;
        neigh <= '0;
        count <= '0;
      end else if (write_phase) begin
        neigh <= '0;
        count <= '0;
        cell_idx <= cell_idx + 1'b1;
        if (cell_idx == '1) begin
          busy <= 1'b0;
          update_done <= 1'b1;
        end
      end else if (busy) begin
        count <= count + 4'(bus.step_cell);
        neigh <= neigh + 4'd1;
      end
    end
  end

endmodule

// ==== hdl/life_top.sv ====
// ****************************
// Game of Life engine, 8 by 8 torus
// Commands come in and text frames go out as byte streams
// with valid/ready, a byte moves when both are high
// ****************************

module life_top (
  input  logic            clk,
  input  logic            boot_reset,
  input  life_pkg::byte_t cmd_data,
  input  logic            cmd_valid,
  output logic            cmd_ready,
  output life_pkg::byte_t out_data,
  output logic            out_valid,
  input  logic            out_ready
);

  logic rand_start;
  logic rand_done;
  logic update_start;
  logic update_done;
  logic copy_start;
  logic copy_done;
  logic print_start;
  logic print_done;

  board_if u_bus ();

  life_ctrl u_ctrl (
    .clk          (clk),
    .boot_reset   (boot_reset),
    .cmd_data     (cmd_data),
    .cmd_valid    (cmd_valid),
    .rand_done    (rand_done),
    .update_done  (update_done),
    .copy_done    (copy_done),
    .print_done   (print_done),
    .cmd_ready    (cmd_ready),
    .rand_start   (rand_start),
    .update_start (update_start),
    .copy_start   (copy_start),
    .print_start  (print_start)
  );

  life_board u_board (
    .clk        (clk),
    .boot_reset (boot_reset),
    .rand_start (rand_start),
    .copy_start (copy_start),
    .rand_done  (rand_done),
    .copy_done  (copy_done),
    .bus        (u_bus.store)
  );

  life_stepper u_stepper (
    .clk          (clk),
    .boot_reset   (boot_reset),
    .update_start (update_start),
    .update_done  (update_done),
    .bus          (u_bus.stepper)
  );

  board_printer u_printer (
    .clk         (clk),
    .boot_reset  (boot_reset),
    .print_start (print_start),
    .out_ready   (out_ready),
    .print_done  (print_done),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .bus         (u_bus.printer)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the Game of Life testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
  --top-module tb_life -f all.f -o sim_life

output=$(./obj_dir/sim_life || true)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi
